//--- compile.f
core_pkg.sv
bus_pkg.sv
reset_hold.sv
req_arbiter.sv
axi_read_channel.sv
axi_write_channel.sv
mem_bridge_top.sv
mem_bridge_properties.sv
tb_mem_bridge.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_mem_bridge -f compile.f -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/Vtb_mem_bridge
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi
exit 0

//--- tb_mem_bridge.sv
module tb_mem_bridge
    import core_pkg::*, bus_pkg::*;
();

    localparam int HOLD       = 16;
    localparam int NUM_TXN    = 400;
    localparam int MAX_CYCLES = 20000;
    localparam int STALL_MAX  = 40;

    typedef struct packed {
        logic              is_data;
        mem_req_t          req;
        logic [DATA_W-1:0] exp_rdata;
    } txn_t;

    logic              Clk;
    logic              Myreset;
    logic              inst_req_i;
    logic [ADDR_W-1:0] inst_addr_i;
    logic              inst_addr_ok_o;
    logic              inst_data_ok_o;
    logic [DATA_W-1:0] inst_rdata_o;
    logic              data_req_i;
    mem_req_t          data_req_info_i;
    logic              data_addr_ok_o;
    logic              data_data_ok_o;
    logic [DATA_W-1:0] data_rdata_o;
    axi_ar_t           ar_o;
    logic              arvalid_o;
    logic              arready_i;
    logic [DATA_W-1:0] rdata_i;
    logic              rvalid_i;
    logic              rready_o;
    axi_aw_t           aw_o;
    logic              awvalid_o;
    logic              awready_i;
    axi_w_t            w_o;
    logic              wvalid_o;
    logic              wready_i;
    logic              bvalid_i;
    logic              bready_o;

    logic [15:0]       lfsr_q;
    logic [DATA_W-1:0] slave_mem [64];
    logic [DATA_W-1:0] shadow_mem [64];  // expected memory contents.
    txn_t              q [$];            // accepted, not yet completed.
    logic              inst_pend;
    logic              data_pend;
    logic              arready_nx;
    logic              rvalid_nx;
    logic              awready_nx;
    logic              wready_nx;
    logic              bvalid_nx;
    logic [DATA_W-1:0] rdata_nx;
    logic [1:0]        ar_cnt;
    logic [1:0]        r_cnt;
    logic [1:0]        aw_cnt;
    logic [1:0]        w_cnt;
    logic [1:0]        b_cnt;
    logic              r_pend;
    logic              b_pend;
    logic              aw_got;
    logic              w_got;
    logic              resp_seen;  // r or b beat seen, data_ok due next.
    logic [7:0]        r_addr;
    logic [7:0]        aw_addr;
    logic [DATA_W-1:0] w_data;
    logic [STRB_W-1:0] w_strb;
    int                accepted;
    int                completed;
    int                cycles;
    int                stall;

    mem_bridge_top #(
        .RESET_HOLD_CYCLES(HOLD)
    ) u_mem_bridge_top (.*);

    initial Clk = 1'b0;
    always #2 Clk = ~Clk;

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r      = {r[30:0], lfsr_q[0]};
            lfsr_q = lfsr_step(lfsr_q);
        end
        return r;
    endfunction

    function automatic logic [3:0] lane_mask(input access_size_t size, input logic [1:0] low);
        logic [3:0] m;
        m = '0;
        for (int b = 0; b < 4; b++) begin
            if (size == SIZE_WORD) begin
                m[b] = 1'b1;
            end else if (size == SIZE_HALF) begin
                m[b] = ((b / 2) == int'(low[1]));
            end else begin
                m[b] = (b == int'(low));
            end
        end
        return m;
    endfunction

    function automatic logic [31:0] merge_lanes(input logic [31:0] old, input logic [31:0] data,
                                                 input logic [3:0] mask);
        logic [31:0] w;
        w = old;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                w[8*b +: 8] = data[8*b +: 8];  // lanes are not shifted.
            end
        end
        return w;
    endfunction

    function automatic mem_req_t random_data_req();
        mem_req_t   r;
        logic [1:0] sz;
        logic [7:0] a;
        sz = 2'(rand_bits(2));
        if (sz == 2'd3) begin
            sz = 2'd2;  // no 8-byte access on a 32-bit bus.
        end
        a = 8'(rand_bits(8));
        if (sz != 2'd0) begin
            a[0] = 1'b0;
        end
        if (sz == 2'd2) begin
            a[1] = 1'b0;
        end
        r.write = 1'(rand_bits(1));
        r.size  = access_size_t'(sz);
        r.addr  = {24'd0, a};
        r.wdata = rand_bits(32);
        return r;
    endfunction

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            fail_stop($sformatf("Mismatch at time %0t: %s, got %h, expected %h",
                                $time, what, got, exp));
        end
    endtask

    // ready with a random 0 to 3 cycle delay per beat.
    task automatic step_ready(input logic valid, input logic ready, inout logic [1:0] cnt,
                              output logic ready_nx);
        if (valid && ready) begin
            cnt      = 2'(rand_bits(2));
            ready_nx = (cnt == 2'd0);
        end else if (ready || !valid) begin
            ready_nx = ready;
        end else if (cnt == 2'd0) begin
            ready_nx = 1'b1;
        end else begin
            cnt      = cnt - 2'd1;
            ready_nx = 1'b0;
        end
    endtask

    task automatic drive_cycle(input logic both);
        if (!inst_pend && accepted < NUM_TXN && (both || rand_bits(1) == 1)) begin
            inst_addr_i = {24'd0, 6'(rand_bits(6)), 2'b00};
            inst_pend   = 1'b1;
        end
        if (!data_pend && accepted < NUM_TXN && (both || rand_bits(1) == 1)) begin
            data_req_info_i = random_data_req();
            data_pend       = 1'b1;
        end
        inst_req_i = inst_pend;
        data_req_i = data_pend;
        arready_i  = arready_nx;
        rvalid_i   = rvalid_nx;
        rdata_i    = rdata_nx;
        awready_i  = awready_nx;
        wready_i   = wready_nx;
        bvalid_i   = bvalid_nx;
    endtask

    task automatic accept(input logic is_data, input mem_req_t req);
        txn_t       t;
        logic [5:0] idx;
        idx         = req.addr[7:2];
        t.is_data   = is_data;
        t.req       = req;
        t.exp_rdata = shadow_mem[idx];
        if (req.write) begin
            shadow_mem[idx] = merge_lanes(shadow_mem[idx], req.wdata,
                                          lane_mask(req.size, req.addr[1:0]));
        end
        q.push_back(t);
        accepted++;
    endtask

    task automatic slave_cycle();
        if (rvalid_i && rready_o) begin
            rvalid_nx = 1'b0;
            resp_seen = 1'b1;
        end
        if (arvalid_o && arready_i) begin
            check_eq(ar_o.addr, q[0].req.addr, "ar address");
            check_eq(32'(ar_o.size), 32'(q[0].req.size), "ar size");
            r_addr = ar_o.addr[7:0];
            r_pend = 1'b1;
            r_cnt  = 2'(rand_bits(2));
        end
        if (r_pend) begin
            if (r_cnt == 2'd0) begin
                rvalid_nx = 1'b1;
                rdata_nx  = slave_mem[r_addr[7:2]];
                r_pend    = 1'b0;
            end else begin
                r_cnt = r_cnt - 2'd1;
            end
        end
        if (awvalid_o && awready_i) begin
            check_eq(aw_o.addr, q[0].req.addr, "aw address");
            check_eq(32'(aw_o.size), 32'(q[0].req.size), "aw size");
            aw_addr = aw_o.addr[7:0];
            aw_got  = 1'b1;
        end
        if (wvalid_o && wready_i) begin
            check_eq(w_o.data, q[0].req.wdata, "w data");
            check_eq(32'(w_o.strb), 32'(lane_mask(q[0].req.size, q[0].req.addr[1:0])),
                     "w strobes");
            w_data = w_o.data;
            w_strb = w_o.strb;
            w_got  = 1'b1;
        end
        if (aw_got && w_got) begin
            slave_mem[aw_addr[7:2]] = merge_lanes(slave_mem[aw_addr[7:2]], w_data, w_strb);
            aw_got = 1'b0;
            w_got  = 1'b0;
            b_pend = 1'b1;
            b_cnt  = 2'(rand_bits(2));
        end
        if (bvalid_i && bready_o) begin
            bvalid_nx = 1'b0;
            resp_seen = 1'b1;
        end
        if (b_pend) begin
            if (b_cnt == 2'd0) begin
                bvalid_nx = 1'b1;
                b_pend    = 1'b0;
            end else begin
                b_cnt = b_cnt - 2'd1;
            end
        end
        step_ready(arvalid_o, arready_i, ar_cnt, arready_nx);
        step_ready(awvalid_o, awready_i, aw_cnt, awready_nx);
        step_ready(wvalid_o, wready_i, w_cnt, wready_nx);
    endtask

    task automatic sample_cycle();
        logic idle;
        logic front_data;
        txn_t t;
        idle       = (cycles > HOLD) && (q.size() == 0);
        front_data = (q.size() > 0) ? q[0].is_data : 1'b0;
        check_eq(32'(data_addr_ok_o), 32'(idle && data_req_i), "data addr_ok");
        check_eq(32'(inst_addr_ok_o), 32'(idle && inst_req_i && !data_req_i), "inst addr_ok");
        if (q.size() == 0) begin
            check_eq(32'({arvalid_o, rready_o, awvalid_o, wvalid_o, bready_o}), 0,
                     "bus active with nothing outstanding");
        end
        check_eq(32'(data_data_ok_o), 32'(resp_seen && front_data), "data data_ok");
        check_eq(32'(inst_data_ok_o), 32'(resp_seen && !front_data), "inst data_ok");
        if (resp_seen) begin
            t = q.pop_front();
            if (!t.req.write) begin
                check_eq(front_data ? data_rdata_o : inst_rdata_o, t.exp_rdata, "read word");
            end
            resp_seen = 1'b0;
            stall     = 0;
            completed++;
        end
        if (data_addr_ok_o) begin
            accept(1'b1, data_req_info_i);
            data_pend = 1'b0;
        end else if (inst_addr_ok_o) begin
            accept(1'b0, '{write: 1'b0, size: SIZE_WORD, addr: inst_addr_i, wdata: '0});
            inst_pend = 1'b0;
        end
        slave_cycle();
        if (q.size() > 0) begin
            stall++;
        end
        if (stall > STALL_MAX) begin
            fail_stop("no data_ok arrived within 40 cycles of an accept");
        end
    endtask

    initial begin
        lfsr_q = 16'd59;
        for (int i = 0; i < 64; i++) begin
            slave_mem[i]  = 32'h1f2e3d4c ^ (32'(i) * 32'h01000193);
            shadow_mem[i] = slave_mem[i];
        end
        {inst_pend, data_pend, r_pend, b_pend, aw_got, w_got, resp_seen} = '0;
        {arready_nx, rvalid_nx, awready_nx, wready_nx, bvalid_nx}       = '0;
        {ar_cnt, r_cnt, aw_cnt, w_cnt, b_cnt}                           = '0;
        rdata_nx  = '0;
        accepted  = 0;
        completed = 0;
        cycles    = 0;
        stall     = 0;
        Myreset   = 1'b1;
        drive_cycle(1'b1);  // both ports request through reset and hold.
        repeat (5) @(negedge Clk);
        Myreset = 1'b0;
        while (completed < NUM_TXN && cycles < MAX_CYCLES) begin
            drive_cycle(1'b0);
            #1;
            sample_cycle();
            cycles++;
            @(negedge Clk);
        end
        if (completed >= NUM_TXN) begin
            $display("No errors");
            $finish;
        end else begin
            fail_stop("run timed out before all transactions completed");
        end
    end

endmodule

//--- mem_bridge_properties.sv
module mem_bridge_properties import bus_pkg::*; (
    input logic    Clk,
    input logic    Myreset,
    input axi_ar_t ar_i,
    input logic    arvalid_i,
    input logic    arready_i,
    input axi_aw_t aw_i,
    input logic    awvalid_i,
    input logic    awready_i,
    input axi_w_t  w_i,
    input logic    wvalid_i,
    input logic    wready_i,
    input logic    inst_addr_ok_i,
    input logic    inst_data_ok_i,
    input logic    data_addr_ok_i,
    input logic    data_data_ok_i
);

    logic busy_q;  // between accept and data_ok.

    always_ff @(posedge Clk) begin
        if (Myreset) begin
            busy_q <= 1'b0;
        end else if (inst_addr_ok_i || data_addr_ok_i) begin
            busy_q <= 1'b1;
        end else if (inst_data_ok_i || data_data_ok_i) begin
            busy_q <= 1'b0;
        end
    end

    ar_hold: assert property (@(posedge Clk) disable iff (Myreset)
        arvalid_i && !arready_i |=> arvalid_i && $stable(ar_i))
        else $error("arvalid or ar payload changed before arready");

    aw_hold: assert property (@(posedge Clk) disable iff (Myreset)
        awvalid_i && !awready_i |=> awvalid_i && $stable(aw_i))
        else $error("awvalid or aw payload changed before awready");

    w_hold: assert property (@(posedge Clk) disable iff (Myreset)
        wvalid_i && !wready_i |=> wvalid_i && $stable(w_i))
        else $error("wvalid or w payload changed before wready");

    one_grant: assert property (@(posedge Clk) disable iff (Myreset)
        !(inst_addr_ok_i && data_addr_ok_i))
        else $error("both ports got addr_ok in the same cycle");

    one_outstanding: assert property (@(posedge Clk) disable iff (Myreset)
        busy_q |-> !(inst_addr_ok_i || data_addr_ok_i))
        else $error("request accepted while another access was outstanding");

endmodule

bind mem_bridge_top mem_bridge_properties u_mem_bridge_properties (
    .Clk           (Clk),
    .Myreset       (Myreset),
    .ar_i          (ar_o),
    .arvalid_i     (arvalid_o),
    .arready_i     (arready_i),
    .aw_i          (aw_o),
    .awvalid_i     (awvalid_o),
    .awready_i     (awready_i),
    .w_i           (w_o),
    .wvalid_i      (wvalid_o),
    .wready_i      (wready_i),
    .inst_addr_ok_i(inst_addr_ok_o),
    .inst_data_ok_i(inst_data_ok_o),
    .data_addr_ok_i(data_addr_ok_o),
    .data_data_ok_i(data_data_ok_o)
);

//--- mem_bridge_top.sv
module mem_bridge_top import core_pkg::*, bus_pkg::*; #(
    parameter int RESET_HOLD_CYCLES = 16
) (
    input  logic              Clk,
    input  logic              Myreset,

    input  logic              inst_req_i,
    input  logic [ADDR_W-1:0] inst_addr_i,
    output logic              inst_addr_ok_o,
    output logic              inst_data_ok_o,
    output logic [DATA_W-1:0] inst_rdata_o,

    input  logic              data_req_i,
    input  mem_req_t          data_req_info_i,
    output logic              data_addr_ok_o,
    output logic              data_data_ok_o,
    output logic [DATA_W-1:0] data_rdata_o,

    output axi_ar_t           ar_o,
    output logic              arvalid_o,
    input  logic              arready_i,
    input  logic [DATA_W-1:0] rdata_i,
    input  logic              rvalid_i,
    output logic              rready_o,

    output axi_aw_t           aw_o,
    output logic              awvalid_o,
    input  logic              awready_i,
    output axi_w_t            w_o,
    output logic              wvalid_o,
    input  logic              wready_i,
    input  logic              bvalid_i,
    output logic              bready_o
);

    logic              core_rst;
    logic              rd_start;
    logic              rd_done;
    logic              wr_start;
    logic              wr_done;
    mem_req_t          req;
    logic [DATA_W-1:0] rd_word;

    reset_hold #(
        .RESET_HOLD_CYCLES(RESET_HOLD_CYCLES)
    ) u_reset_hold (
        .Clk       (Clk),
        .Myreset   (Myreset),
        .core_rst_o(core_rst)
    );

    req_arbiter u_req_arbiter (
        .Clk            (Clk),
        .Myreset        (Myreset),
        .core_rst_i     (core_rst),
        .inst_req_i     (inst_req_i),
        .inst_addr_i    (inst_addr_i),
        .inst_addr_ok_o (inst_addr_ok_o),
        .inst_data_ok_o (inst_data_ok_o),
        .data_req_i     (data_req_i),
        .data_req_info_i(data_req_info_i),
        .data_addr_ok_o (data_addr_ok_o),
        .data_data_ok_o (data_data_ok_o),
        .rd_start_o     (rd_start),
        .rd_done_i      (rd_done),
        .wr_start_o     (wr_start),
        .wr_done_i      (wr_done),
        .req_o          (req)
    );

    axi_read_channel u_axi_read_channel (
        .Clk       (Clk),
        .Myreset   (Myreset),
        .core_rst_i(core_rst),
        .start_i   (rd_start),
        .req_i     (req),
        .ar_o      (ar_o),
        .arvalid_o (arvalid_o),
        .arready_i (arready_i),
        .rdata_i   (rdata_i),
        .rvalid_i  (rvalid_i),
        .rready_o  (rready_o),
        .done_o    (rd_done),
        .rdata_o   (rd_word)
    );

    axi_write_channel u_axi_write_channel (
        .Clk       (Clk),
        .Myreset   (Myreset),
        .core_rst_i(core_rst),
        .start_i   (wr_start),
        .req_i     (req),
        .aw_o      (aw_o),
        .awvalid_o (awvalid_o),
        .awready_i (awready_i),
        .w_o       (w_o),
        .wvalid_o  (wvalid_o),
        .wready_i  (wready_i),
        .bvalid_i  (bvalid_i),
        .bready_o  (bready_o),
        .done_o    (wr_done)
    );

    // one read word, qualified per port by its data_ok.
    assign inst_rdata_o = rd_word;
    assign data_rdata_o = rd_word;

endmodule

//--- axi_write_channel.sv
module axi_write_channel import core_pkg::*, bus_pkg::*; (
    input  logic     Clk,
    input  logic     Myreset,
    input  logic     core_rst_i,

    input  logic     start_i,
    input  mem_req_t req_i,

    output axi_aw_t  aw_o,
    output logic     awvalid_o,
    input  logic     awready_i,

    output axi_w_t   w_o,
    output logic     wvalid_o,
    input  logic     wready_i,

    input  logic     bvalid_i,
    output logic     bready_o,

    output logic     done_o
);

    logic              aw_pend_q;
    logic              w_pend_q;
    logic              b_wait_q;
    logic              done_q;
    logic              aw_left;
    logic              w_left;
    logic [STRB_W-1:0] strb;

    // byte lanes from size and low address bits.
    always_comb begin
        case (req_i.size)
            SIZE_BYTE: strb = 4'b0001 << req_i.addr[1:0];
            SIZE_HALF: strb = req_i.addr[1] ? 4'b1100 : 4'b0011;
            default:   strb = 4'b1111;
        endcase
    end

    // still pending after this cycle.
    assign aw_left = aw_pend_q && !awready_i;
    assign w_left  = w_pend_q && !wready_i;

    always_ff @(posedge Clk) begin
        if (Myreset || core_rst_i) begin
            aw_pend_q <= 1'b0;
            w_pend_q  <= 1'b0;
            b_wait_q  <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (start_i) begin
                aw_pend_q <= 1'b1;
                w_pend_q  <= 1'b1;
            end else begin
                aw_pend_q <= aw_left;
                w_pend_q  <= w_left;
                if ((aw_pend_q || w_pend_q) && !aw_left && !w_left) begin
                    b_wait_q <= 1'b1;  // both sides through.
                end
            end
            if (b_wait_q && bvalid_i) begin
                b_wait_q <= 1'b0;
                done_q   <= 1'b1;
            end
        end
    end

    assign aw_o      = '{addr: req_i.addr, size: {1'b0, req_i.size}};
    assign w_o       = '{data: req_i.wdata, strb: strb};
    assign awvalid_o = aw_pend_q;
    assign wvalid_o  = w_pend_q;
    assign bready_o  = b_wait_q;
    assign done_o    = done_q;

endmodule

//--- axi_read_channel.sv
module axi_read_channel import core_pkg::*, bus_pkg::*; (
    input  logic              Clk,
    input  logic              Myreset,
    input  logic              core_rst_i,

    input  logic              start_i,
    input  mem_req_t          req_i,

    output axi_ar_t           ar_o,
    output logic              arvalid_o,
    input  logic              arready_i,
    input  logic [DATA_W-1:0] rdata_i,
    input  logic              rvalid_i,
    output logic              rready_o,

    output logic              done_o,
    output logic [DATA_W-1:0] rdata_o
);

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA,
        RD_DONE
    } rd_state_t;

    rd_state_t         state_q;
    logic [DATA_W-1:0] rdata_q;

    always_ff @(posedge Clk) begin
        if (Myreset || core_rst_i) begin
            state_q <= RD_IDLE;
        end else begin
            case (state_q)
                RD_IDLE: if (start_i) state_q <= RD_ADDR;
                RD_ADDR: if (arready_i) state_q <= RD_DATA;
                RD_DATA: if (rvalid_i) state_q <= RD_DONE;
                default: state_q <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (state_q == RD_DATA && rvalid_i) begin
            rdata_q <= rdata_i;  // capture the single beat.
        end
    end

    assign ar_o      = '{addr: req_i.addr, size: {1'b0, req_i.size}};
    assign arvalid_o = (state_q == RD_ADDR);
    assign rready_o  = (state_q == RD_DATA);
    assign done_o    = (state_q == RD_DONE);
    assign rdata_o   = rdata_q;

endmodule

//--- req_arbiter.sv
module req_arbiter import core_pkg::*; (
    input  logic              Clk,
    input  logic              Myreset,
    input  logic              core_rst_i,

    input  logic              inst_req_i,
    input  logic [ADDR_W-1:0] inst_addr_i,
    output logic              inst_addr_ok_o,
    output logic              inst_data_ok_o,

    input  logic              data_req_i,
    input  mem_req_t          data_req_info_i,
    output logic              data_addr_ok_o,
    output logic              data_data_ok_o,

    output logic              rd_start_o,
    input  logic              rd_done_i,
    output logic              wr_start_o,
    input  logic              wr_done_i,

    output mem_req_t          req_o
);

    logic     busy_q;
    logic     owner_data_q;  // data port owns the access.
    mem_req_t req_q;
    mem_req_t inst_req;
    mem_req_t win_req;
    logic     can_accept;
    logic     accept;
    logic     done;

    // instruction fetches are always word reads.
    always_comb begin
        inst_req      = '0;
        inst_req.size = SIZE_WORD;
        inst_req.addr = inst_addr_i;
    end

    assign can_accept = !busy_q && !core_rst_i;

    assign data_addr_ok_o = can_accept && data_req_i;
    assign inst_addr_ok_o = can_accept && inst_req_i && !data_req_i;  // data wins a tie.
    assign accept         = data_addr_ok_o || inst_addr_ok_o;

    assign win_req = data_req_i ? data_req_info_i : inst_req;

    assign rd_start_o = accept && !win_req.write;
    assign wr_start_o = accept && win_req.write;

    assign done = rd_done_i || wr_done_i;

    always_ff @(posedge Clk) begin
        if (Myreset || core_rst_i) begin
            busy_q       <= 1'b0;
            owner_data_q <= 1'b0;
        end else if (accept) begin
            busy_q       <= 1'b1;
            owner_data_q <= data_req_i;
        end else if (done) begin
            busy_q <= 1'b0;  // free again the cycle after data_ok.
        end
    end

    always_ff @(posedge Clk) begin
        if (accept) begin
            req_q <= win_req;
        end
    end

    assign inst_data_ok_o = done && !owner_data_q;
    assign data_data_ok_o = done && owner_data_q;

    assign req_o = req_q;  // held stable while busy.

endmodule

//--- reset_hold.sv
module reset_hold #(
    parameter int RESET_HOLD_CYCLES = 16
) (
    input  logic Clk,
    input  logic Myreset,
    output logic core_rst_o
);

    localparam int CNT_W = $clog2(RESET_HOLD_CYCLES + 1);

    logic [CNT_W-1:0] cnt_q;
    logic             core_rst_q;

    always_ff @(posedge Clk) begin
        if (Myreset) begin
            cnt_q      <= '0;
            core_rst_q <= 1'b1;
        end else begin
            if (cnt_q != CNT_W'(RESET_HOLD_CYCLES)) begin
                cnt_q <= cnt_q + 1'b1;  // saturates at the hold count.
            end
            if (cnt_q == CNT_W'(RESET_HOLD_CYCLES)) begin
                core_rst_q <= 1'b0;
            end
        end
    end

    assign core_rst_o = core_rst_q;

endmodule

//--- bus_pkg.sv
package bus_pkg;

    import core_pkg::*;

    localparam int AXI_SIZE_W = 3;
    localparam int STRB_W     = DATA_W / 8;

    // read address channel payload.
    typedef struct packed {
        logic [ADDR_W-1:0]     addr;
        logic [AXI_SIZE_W-1:0] size;
    } axi_ar_t;

    // write address channel payload, same layout as ar.
    typedef struct packed {
        logic [ADDR_W-1:0]     addr;
        logic [AXI_SIZE_W-1:0] size;
    } axi_aw_t;

    // write data payload; single beat so last is implied.
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
    } axi_w_t;

endpackage

//--- core_pkg.sv
package core_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // log2 of the byte count, so it maps straight onto the AXI size field.
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } access_size_t;

    typedef struct packed {
        logic              write;  // store when set.
        access_size_t      size;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;  // not lane shifted.
    } mem_req_t;

endpackage
